/* tests/uart_input.txt */
# cmd a b n, all hex; n repeats, S and R step the byte in a or b by one each time
# W addr data | R addr expect | S char badpar | Q irq_level 0 | D cycles 0
# After reset
R 1 00 1
R 2 c1 1
R 5 60 1
Q 0 00 1
# Non-FIFO mode, receive data interrupt
W 1 01 1
S 41 0 1
Q 1 00 1
R 5 61 1
R 2 c4 1
R 0 41 1
Q 0 00 1
# Even parity, bad parity cleared by ISR read then by LSR read
W 3 18 1
W 1 05 1
S 5a 1 1
Q 1 00 1
R 2 c6 1
R 5 65 1
R 2 c4 1
R 0 5a 1
S a5 1 1
Q 1 00 1
R 5 65 1
R 2 c4 1
R 0 a5 1
Q 0 00 1
# FIFO mode, trigger 4, with flush
W 2 43 1
S 11 0 4
Q 1 00 1
R 2 c4 1
R 0 11 4
R 2 c4 1
R 2 c1 1
Q 0 00 1
# Character timeout
S 55 0 2
D 190 00 1
Q 1 00 1
R 2 cc 1
R 0 55 1
R 2 c1 1
R 0 56 1
R 2 c1 1
# Overrun, sixteen stored, one held in the receiver, one lost
S 80 0 12
Q 1 00 1
R 2 c6 1
R 5 63 1
R 5 61 1
R 0 80 11
R 5 60 1
R 2 c4 1
R 2 c1 1
Q 0 00 1

/* all.f */
design/uart_cfg_pkg.sv
design/uart_reg_pkg.sv
design/uart_char_if.sv
design/uart_receiver.sv
design/uart_rx_fifo.sv
design/uart_interrupts.sv
design/uart_regs.sv
design/uart_rx_top.sv
tests/tb_clock.sv
tests/uart_assert.sv
tests/tb_uart.sv

/* Makefile */
TOP := tb_uart
LOG := sim.log

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q '^TEST OK$$' $(LOG)

build:
	verilator --binary --timing --assert -j 0 -f all.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

/* tests/tb_uart.sv */
`timescale 1ns/1ns

module tb_uart;

  localparam int DRIVE_DLY  = 5;
  // Longest frame, start + 8 data + parity + stop
  localparam int FRAME_CLKS = 11 * uart_cfg_pkg::CLKS_PER_BIT;

  logic       clk;
  logic       rst;
  logic       rx;
  logic       bus_valid;
  logic       bus_ready;
  logic       bus_we;
  logic [2:0] bus_addr;
  logic [7:0] bus_wdata;
  logic       bus_rvalid;
  logic       bus_rready;
  logic [7:0] bus_rdata;
  logic       irq;

  // Command list from the stimulus file
  logic [7:0]  cmd_q [$];
  logic [15:0] arg_a_q [$];
  logic [7:0]  arg_b_q [$];
  int          rep_q [$];
  integer      seed;
  int          budget;
  // Line format as last written to LCR
  logic        par_en;
  logic        par_even;

  tb_clock u_clock (
    .clk_o (clk)
  );

  uart_rx_top uut (
    .clk_i        (clk),
    .rst_i        (rst),
    .rx_i         (rx),
    .bus_valid_i  (bus_valid),
    .bus_ready_o  (bus_ready),
    .bus_we_i     (bus_we),
    .bus_addr_i   (bus_addr),
    .bus_wdata_i  (bus_wdata),
    .bus_rvalid_o (bus_rvalid),
    .bus_rready_i (bus_rready),
    .bus_rdata_o  (bus_rdata),
    .irq_o        (irq)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("Error: %s", why);
    $display("TEST FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic watchdog(input int cycles);
    repeat (cycles) @(posedge clk);
    $display("Error: run did not finish within %0d clock cycles", cycles);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus and serial drivers
  ////////////////////////////////////////////////////////////////////////////
  // Inputs change a fixed delay after the rising edge
  task automatic wait_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic bus_request(input logic we, input logic [2:0] addr, input logic [7:0] data);
    logic accepted;
    bus_valid = 1'b1;
    bus_we    = we;
    bus_addr  = addr;
    bus_wdata = data;
    do begin
      // Mid-cycle sample, well clear of the edge
      @(negedge clk);
      accepted = bus_ready;
      wait_cycle();
    end while (!accepted);
    bus_valid = 1'b0;
    bus_we    = 1'b0;
  endtask

  task automatic bus_read(input logic [2:0] addr, output logic [7:0] data);
    int   stall;
    logic got;
    bus_request(1'b0, addr, 8'h00);
    // Random back-pressure before taking the response
    stall = $random(seed) & 3;
    // Unclaimed response holds rvalid and blocks new requests
    repeat (stall) begin
      @(negedge clk);
      check_val("bus_rvalid_o", {7'd0, bus_rvalid}, 8'h01);
      check_val("bus_ready_o", {7'd0, bus_ready}, 8'h00);
      wait_cycle();
    end
    bus_rready = 1'b1;
    do begin
      @(negedge clk);
      got  = bus_rvalid;
      data = bus_rdata;
      wait_cycle();
    end while (!got);
    bus_rready = 1'b0;
  endtask

  task automatic drive_bit(input logic value);
    rx = value;
    repeat (uart_cfg_pkg::CLKS_PER_BIT) wait_cycle();
  endtask

  task automatic send_char(input logic [7:0] data, input logic bad_par);
    logic par_bit;
    int   i;
    // Even parity gives an even count of ones, odd an odd count
    par_bit = (^data) ^ ~par_even ^ bad_par;
    drive_bit(1'b0);
    for (i = 0; i < 8; i++) begin
      drive_bit(data[i]);
    end
    if (par_en) begin
      drive_bit(par_bit);
    end
    drive_bit(1'b1);
  endtask

  task automatic wait_irq(input logic level);
    while (irq !== level) begin
      wait_cycle();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus file
  ////////////////////////////////////////////////////////////////////////////
  task automatic load_commands();
    integer      fd;
    integer      n;
    string       line;
    logic [7:0]  c;
    logic [15:0] a;
    logic [7:0]  b;
    integer      r;
    fd = $fopen("tests/uart_input.txt", "r");
    if (fd == 0) begin
      abort_run("stimulus file tests/uart_input.txt could not be opened");
    end
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%c %h %h %h", c, a, b, r);
      // Lines starting with # are comments
      if (c != "#") begin
        if (n != 4) begin
          abort_run("stimulus file holds a malformed command line");
        end
        cmd_q.push_back(c);
        arg_a_q.push_back(a);
        arg_b_q.push_back(b);
        rep_q.push_back(r);
      end
    end
    $fclose(fd);
  endtask

  // Frames, idle waits and bus traffic, plus a margin
  function automatic int run_budget();
    int total;
    total = 2000;
    foreach (cmd_q[k]) begin
      if (cmd_q[k] == "S") begin
        total += rep_q[k] * FRAME_CLKS;
      end else if (cmd_q[k] == "D") begin
        total += rep_q[k] * int'(arg_a_q[k]);
      end else begin
        total += rep_q[k] * 12;
      end
    end
    return total;
  endfunction

  // Repeated S and R step the character by one each time
  task automatic run_command(input logic [7:0] c, input logic [15:0] a,
                             input logic [7:0] b, input int reps);
    logic [7:0] got;
    logic [7:0] step;
    step = 8'd0;
    repeat (reps) begin
      case (c)
        "W": begin
          bus_write_track(a[2:0], b);
        end
        "R": begin
          bus_read(a[2:0], got);
          check_val($sformatf("bus_rdata_o (addr %0h)", a[2:0]), got, b + step);
        end
        "S": send_char(a[7:0] + step, b[0]);
        "Q": wait_irq(a[0]);
        "D": repeat (a) wait_cycle();
        default: abort_run("stimulus file holds an unknown command letter");
      endcase
      step = step + 8'd1;
    end
  endtask

  task automatic bus_write_track(input logic [2:0] addr, input logic [7:0] data);
    bus_request(1'b1, addr, data);
    // LCR bit 3 parity enable, bit 4 even parity
    if (addr == uart_reg_pkg::ADDR_LCR) begin
      par_en   = data[3];
      par_even = data[4];
    end
  endtask

  initial begin
    seed       = 13;
    rst        = 1'b1;
    rx         = 1'b1;
    bus_valid  = 1'b0;
    bus_we     = 1'b0;
    bus_addr   = 3'd0;
    bus_wdata  = 8'h00;
    bus_rready = 1'b0;
    par_en     = 1'b0;
    par_even   = 1'b0;
    load_commands();
    budget = run_budget();
    fork
      watchdog(budget);
    join_none
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;
    foreach (cmd_q[k]) begin
      run_command(cmd_q[k], arg_a_q[k], arg_b_q[k], rep_q[k]);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

/* tests/uart_assert.sv */
`timescale 1ns/1ns

module uart_fifo_assert (
  input logic                           clk_i,
  input logic                           rst_i,
  input logic                           flush_i,
  input logic [uart_cfg_pkg::FIFO_AW:0] count_i,
  input logic                           in_valid_i,
  input logic                           in_ready_i,
  input logic                           valid_i,
  input logic                           ready_i,
  input uart_reg_pkg::rx_char_t         data_i
);

  logic [uart_cfg_pkg::FIFO_AW:0] occ_q;

  // Occupancy rebuilt from the transfers seen on both links
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      occ_q <= '0;
    end else begin
      case ({in_valid_i && in_ready_i, valid_i && ready_i})
        2'b10:   occ_q <= occ_q + 1'b1;
        2'b01:   occ_q <= occ_q - 1'b1;
        default: occ_q <= occ_q;
      endcase
    end
  end

  // Occupancy never past the last entry
  count_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    count_i <= uart_cfg_pkg::FIFO_FULL)
    else $error("FIFO count %0d above depth", count_i);

  // Output valid means something was pushed and not yet popped
  valid_count: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_i == (occ_q != '0))
    else $error("FIFO valid %0b with %0d characters transferred in", valid_i, occ_q);

  // Stalled head keeps its payload, a flush may drop it
  head_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_i && !ready_i |=> !valid_i || $stable(data_i))
    else $error("FIFO head changed while stalled");

endmodule

bind uart_rx_fifo uart_fifo_assert u_fifo_assert (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .flush_i    (flush_i),
  .count_i    (count_q),
  .in_valid_i (char_i.valid),
  .in_ready_i (char_i.ready),
  .valid_i    (char_o.valid),
  .ready_i    (char_o.ready),
  .data_i     (char_o.data)
);

/* tests/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
  output logic clk_o
);

  // 40 ns period
  localparam int HALF_PERIOD = 20;

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

endmodule

/* design/uart_rx_top.sv */
`timescale 1ns/1ns

module uart_rx_top (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       rx_i,
  input  logic       bus_valid_i,
  output logic       bus_ready_o,
  input  logic       bus_we_i,
  input  logic [2:0] bus_addr_i,
  input  logic [7:0] bus_wdata_i,
  output logic       bus_rvalid_o,
  input  logic       bus_rready_i,
  output logic [7:0] bus_rdata_o,
  output logic       irq_o
);

  uart_reg_pkg::ier_t ier;
  uart_reg_pkg::fcr_t fcr;
  uart_reg_pkg::lcr_t lcr;
  uart_reg_pkg::isr_t isr;
  logic               overrun;
  logic               flush;
  logic               trigger;
  logic               timeout;
  logic               rls_event;
  logic               read_lsr;
  logic               read_rhr;
  logic               read_isr;

  // Receiver to FIFO, FIFO to register block
  uart_char_if char_in ();
  uart_char_if char_out ();

  uart_receiver u_receiver (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .rx_i      (rx_i),
    .lcr_i     (lcr),
    .char_o    (char_in),
    .overrun_o (overrun)
  );

  uart_rx_fifo u_fifo (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .fcr_i     (fcr),
    .flush_i   (flush),
    .char_i    (char_in),
    .char_o    (char_out),
    .trigger_o (trigger),
    .timeout_o (timeout)
  );

  uart_regs u_regs (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .bus_valid_i  (bus_valid_i),
    .bus_ready_o  (bus_ready_o),
    .bus_we_i     (bus_we_i),
    .bus_addr_i   (bus_addr_i),
    .bus_wdata_i  (bus_wdata_i),
    .bus_rvalid_o (bus_rvalid_o),
    .bus_rready_i (bus_rready_i),
    .bus_rdata_o  (bus_rdata_o),
    .char_i       (char_out),
    .overrun_i    (overrun),
    .isr_i        (isr),
    .ier_o        (ier),
    .fcr_o        (fcr),
    .lcr_o        (lcr),
    .flush_o      (flush),
    .rls_event_o  (rls_event),
    .read_lsr_o   (read_lsr),
    .read_rhr_o   (read_rhr),
    .read_isr_o   (read_isr)
  );

  uart_interrupts u_interrupts (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ier_i        (ier),
    .fifo_en_i    (fcr.fifo_en),
    .rls_event_i  (rls_event),
    .rx_trigger_i (trigger),
    .rx_timeout_i (timeout),
    .read_lsr_i   (read_lsr),
    .read_rhr_i   (read_rhr),
    .read_isr_i   (read_isr),
    .isr_o        (isr),
    .irq_o        (irq_o)
  );

endmodule

/* design/uart_regs.sv */
`timescale 1ns/1ns

module uart_regs (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               bus_valid_i,
  output logic               bus_ready_o,
  input  logic               bus_we_i,
  input  logic [2:0]         bus_addr_i,
  input  logic [7:0]         bus_wdata_i,
  output logic               bus_rvalid_o,
  input  logic               bus_rready_i,
  output logic [7:0]         bus_rdata_o,
  uart_char_if.sink          char_i,
  input  logic               overrun_i,
  input  uart_reg_pkg::isr_t isr_i,
  output uart_reg_pkg::ier_t ier_o,
  output uart_reg_pkg::fcr_t fcr_o,
  output uart_reg_pkg::lcr_t lcr_o,
  output logic               flush_o,
  output logic               rls_event_o,
  output logic               read_lsr_o,
  output logic               read_rhr_o,
  output logic               read_isr_o
);

  uart_reg_pkg::reg_word_u wword;
  uart_reg_pkg::reg_word_u rword;
  logic [7:0]              lsr;
  logic                    wr;
  logic                    rd;
  logic                    overrun_q;
  logic                    head_seen_q;
  logic                    head_err;

  // Stall only while a response is unclaimed
  assign bus_ready_o = ~bus_rvalid_o | bus_rready_i;
  assign wr = bus_valid_i & bus_ready_o & bus_we_i;
  assign rd = bus_valid_i & bus_ready_o & ~bus_we_i;
  assign wword.raw = bus_wdata_i;

  assign read_rhr_o = rd & (bus_addr_i == uart_reg_pkg::ADDR_RHR);
  assign read_isr_o = rd & (bus_addr_i == uart_reg_pkg::ADDR_ISR_FCR);
  assign read_lsr_o = rd & (bus_addr_i == uart_reg_pkg::ADDR_LSR);
  // RHR read pops the head
  assign char_i.ready = read_rhr_o;
  assign flush_o = wr & (bus_addr_i == uart_reg_pkg::ADDR_ISR_FCR) & wword.fcr.flush;

  // Error bits belong to the head character, THRE and TEMT tied high
  assign lsr = {1'b0, 1'b1, 1'b1,
                char_i.valid & char_i.data.brk,
                char_i.valid & char_i.data.frame_err,
                char_i.valid & char_i.data.parity_err,
                overrun_q,
                char_i.valid};

  assign head_err = char_i.valid &
                    (char_i.data.brk | char_i.data.frame_err | char_i.data.parity_err);
  // New head with an error, or a lost character
  assign rls_event_o = (head_err & ~head_seen_q) | overrun_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ier_o        <= '0;
      fcr_o        <= '0;
      lcr_o        <= '0;
      overrun_q    <= 1'b0;
      head_seen_q  <= 1'b0;
      bus_rvalid_o <= 1'b0;
    end else begin
      if (wr && bus_addr_i == uart_reg_pkg::ADDR_IER) begin
        ier_o <= wword.ier;
      end
      if (wr && bus_addr_i == uart_reg_pkg::ADDR_ISR_FCR) begin
        fcr_o       <= wword.fcr;
        // Flush is self-clearing
        fcr_o.flush <= 1'b0;
      end
      if (wr && bus_addr_i == uart_reg_pkg::ADDR_LCR) begin
        lcr_o <= wword.lcr;
      end
      if (read_lsr_o) begin
        overrun_q <= 1'b0;
      end
      if (overrun_i) begin
        overrun_q <= 1'b1;
      end
      head_seen_q <= char_i.valid & ~read_rhr_o;
      if (bus_rready_i) begin
        bus_rvalid_o <= 1'b0;
      end
      if (rd) begin
        bus_rvalid_o <= 1'b1;
      end
    end
  end

  // Read mux
  always_comb begin
    rword.raw = '0;
    case (bus_addr_i)
      uart_reg_pkg::ADDR_RHR:     rword.raw = char_i.data.data;
      uart_reg_pkg::ADDR_IER:     rword.ier = ier_o;
      uart_reg_pkg::ADDR_ISR_FCR: rword.isr = isr_i;
      uart_reg_pkg::ADDR_LCR:     rword.lcr = lcr_o;
      uart_reg_pkg::ADDR_LSR:     rword.raw = lsr;
      default:                    rword.raw = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd) begin
      bus_rdata_o <= rword.raw;
    end
  end

endmodule

/* design/uart_interrupts.sv */
`timescale 1ns/1ns

module uart_interrupts (
  input  logic               clk_i,
  input  logic               rst_i,
  input  uart_reg_pkg::ier_t ier_i,
  input  logic               fifo_en_i,
  input  logic               rls_event_i,
  input  logic               rx_trigger_i,
  input  logic               rx_timeout_i,
  input  logic               read_lsr_i,
  input  logic               read_rhr_i,
  input  logic               read_isr_i,
  output uart_reg_pkg::isr_t isr_o,
  output logic               irq_o
);

  logic rls_q;
  logic rxdr_q;
  logic timeout_q;
  logic rls_d;
  logic rxdr_d;
  logic timeout_d;
  logic rls_set;
  logic rxdr_set;
  logic timeout_set;
  logic clr_rls;
  logic clr_rx_isr;

  ////////////////////////////////////////////////////////////////////////////
  // Set and clear conditions
  ////////////////////////////////////////////////////////////////////////////
  assign rls_set  = ier_i.rls_en & rls_event_i;
  // In non-FIFO mode the trigger already means one character held
  assign rxdr_set = ier_i.rxdr_en & rx_trigger_i;
  // Timeout only exists with FIFOs on
  assign timeout_set = fifo_en_i & ier_i.rxdr_en & rx_timeout_i;

  assign clr_rls    = read_lsr_i | (read_isr_i & (isr_o.id == uart_reg_pkg::ISR_ID_RLS));
  assign clr_rx_isr = read_isr_i & (isr_o.id == uart_reg_pkg::ISR_ID_RXDR);

  always_comb begin
    rls_d     = rls_q | rls_set;
    rxdr_d    = rxdr_q | rxdr_set;
    timeout_d = timeout_q | timeout_set;
    // Clear wins over a set in the same cycle
    if (clr_rls) begin
      rls_d = 1'b0;
    end
    if (read_rhr_i || clr_rx_isr) begin
      timeout_d = 1'b0;
    end
    if ((read_rhr_i && !fifo_en_i) || clr_rx_isr) begin
      rxdr_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rls_q     <= 1'b0;
      rxdr_q    <= 1'b0;
      timeout_q <= 1'b0;
    end else begin
      rls_q     <= rls_d;
      rxdr_q    <= rxdr_d;
      timeout_q <= timeout_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Priority encoder
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    isr_o.fifos_en = 2'b11;
    isr_o.zero     = 2'b00;
    isr_o.id       = 3'b000;
    isr_o.status   = 1'b1;
    // Line status first, then data, then timeout
    if (rls_q) begin
      isr_o.id     = uart_reg_pkg::ISR_ID_RLS;
      isr_o.status = 1'b0;
    end else if (rxdr_q) begin
      isr_o.id     = uart_reg_pkg::ISR_ID_RXDR;
      isr_o.status = 1'b0;
    end else if (timeout_q) begin
      isr_o.id     = uart_reg_pkg::ISR_ID_TIMEOUT;
      isr_o.status = 1'b0;
    end
  end

  assign irq_o = ~isr_o.status;

endmodule

/* design/uart_rx_fifo.sv */
`timescale 1ns/1ns

module uart_rx_fifo (
  input  logic               clk_i,
  input  logic               rst_i,
  input  uart_reg_pkg::fcr_t fcr_i,
  input  logic               flush_i,
  uart_char_if.sink          char_i,
  uart_char_if.source        char_o,
  output logic               trigger_o,
  output logic               timeout_o
);

  uart_reg_pkg::rx_char_t               mem [uart_cfg_pkg::FIFO_DEPTH];
  logic [uart_cfg_pkg::FIFO_AW-1:0]     wr_ptr_q;
  logic [uart_cfg_pkg::FIFO_AW-1:0]     rd_ptr_q;
  logic [uart_cfg_pkg::FIFO_AW:0]       count_q;
  logic [uart_cfg_pkg::TO_W-1:0]        idle_cnt_q;
  logic [uart_cfg_pkg::FIFO_AW:0]       trig_level;
  logic                                 full;
  logic                                 push;
  logic                                 pop;

  // Non-FIFO mode behaves as a one-entry holding register
  assign full = fcr_i.fifo_en ? (count_q == uart_cfg_pkg::FIFO_FULL) : (count_q != '0);
  assign char_i.ready = ~full;
  assign char_o.valid = (count_q != '0);
  assign char_o.data  = mem[rd_ptr_q];
  assign push = char_i.valid & char_i.ready;
  assign pop  = char_o.valid & char_o.ready;

  always_comb begin
    case (fcr_i.trigger)
      2'b00:   trig_level = uart_cfg_pkg::TRIG_LVL_0;
      2'b01:   trig_level = uart_cfg_pkg::TRIG_LVL_1;
      2'b10:   trig_level = uart_cfg_pkg::TRIG_LVL_2;
      default: trig_level = uart_cfg_pkg::TRIG_LVL_3;
    endcase
  end

  assign trigger_o = fcr_i.fifo_en ? (count_q >= trig_level) : (count_q != '0);
  assign timeout_o = (idle_cnt_q == uart_cfg_pkg::TIMEOUT_LAST);

  // Pointers, count and idle timer
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      idle_cnt_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // Restart on any traffic, saturate at the timeout
      if (push || pop || count_q == '0) begin
        idle_cnt_q <= '0;
      end else if (!timeout_o) begin
        idle_cnt_q <= idle_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= char_i.data;
    end
  end

endmodule

/* design/uart_receiver.sv */
`timescale 1ns/1ns

module uart_receiver (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               rx_i,
  input  uart_reg_pkg::lcr_t lcr_i,
  uart_char_if.source        char_o,
  output logic               overrun_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_PARITY,
    S_STOP
  } state_e;

  state_e                         state_q;
  logic [uart_cfg_pkg::CNT_W-1:0] clk_cnt_q;
  logic [2:0]                     bit_idx_q;
  logic [7:0]                     shift_q;
  logic                           par_bit_q;
  logic                           all_zero_q;
  logic                           valid_q;
  logic                           mid_bit;
  logic                           done;
  uart_reg_pkg::rx_char_t         char_q;
  uart_reg_pkg::rx_char_t         char_new;

  assign mid_bit = (clk_cnt_q == uart_cfg_pkg::BIT_LAST);
  // Stop bit sampled this cycle
  assign done = (state_q == S_STOP) && mid_bit;

  ////////////////////////////////////////////////////////////////////////////
  // Character assembly
  ////////////////////////////////////////////////////////////////////////////
  assign char_new.data = shift_q;
  // Xor of data and parity bit is 1 for odd, 0 for even
  assign char_new.parity_err = lcr_i.par_en & (^shift_q ^ par_bit_q ^ ~lcr_i.even_par);
  assign char_new.frame_err = ~rx_i;
  // Break: every bit low, stop included
  assign char_new.brk = all_zero_q & ~rx_i;

  // Bit clock and FSM
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= S_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
      overrun_o <= 1'b0;
    end else begin
      overrun_o <= 1'b0;
      if (mid_bit) begin
        clk_cnt_q <= '0;
      end else begin
        clk_cnt_q <= clk_cnt_q + 1'b1;
      end
      if (valid_q && char_o.ready) begin
        valid_q <= 1'b0;
      end
      // Held character blocks the new one
      if (done) begin
        if (valid_q && !char_o.ready) begin
          overrun_o <= 1'b1;
        end else begin
          valid_q <= 1'b1;
        end
      end
      case (state_q)
        S_IDLE: begin
          clk_cnt_q <= '0;
          if (!rx_i) begin
            state_q <= S_START;
          end
        end
        S_START: begin
          // Half a bit in, realign to mid-bit
          if (clk_cnt_q == uart_cfg_pkg::HALF_BIT) begin
            clk_cnt_q <= '0;
            bit_idx_q <= '0;
            // High here means a glitch, not a start bit
            state_q   <= rx_i ? S_IDLE : S_DATA;
          end
        end
        S_DATA: begin
          if (mid_bit) begin
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= lcr_i.par_en ? S_PARITY : S_STOP;
            end
          end
        end
        S_PARITY: begin
          if (mid_bit) begin
            state_q <= S_STOP;
          end
        end
        S_STOP: begin
          if (mid_bit) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Data path, LSB first
  always_ff @(posedge clk_i) begin
    if (state_q == S_START) begin
      all_zero_q <= 1'b1;
    end
    if (mid_bit && state_q == S_DATA) begin
      shift_q <= {rx_i, shift_q[7:1]};
      if (rx_i) begin
        all_zero_q <= 1'b0;
      end
    end
    if (mid_bit && state_q == S_PARITY) begin
      par_bit_q <= rx_i;
      if (rx_i) begin
        all_zero_q <= 1'b0;
      end
    end
    if (done && (!valid_q || char_o.ready)) begin
      char_q <= char_new;
    end
  end

  assign char_o.valid = valid_q;
  assign char_o.data  = char_q;

endmodule

/* design/uart_char_if.sv */
`timescale 1ns/1ns

interface uart_char_if;

  // Handshake, transfer when both high at an edge
  logic valid;
  logic ready;
  // Held stable while valid is high
  uart_reg_pkg::rx_char_t data;

  modport source (
    output valid,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    output ready
  );

endinterface

/* design/uart_reg_pkg.sv */
package uart_reg_pkg;

  // Register addresses
  localparam logic [2:0] ADDR_RHR     = 3'd0;
  localparam logic [2:0] ADDR_IER     = 3'd1;
  localparam logic [2:0] ADDR_ISR_FCR = 3'd2;
  localparam logic [2:0] ADDR_LCR     = 3'd3;
  localparam logic [2:0] ADDR_LSR     = 3'd5;

  // Interrupt ids in ISR[3:1]
  localparam logic [2:0] ISR_ID_RLS     = 3'b011;
  localparam logic [2:0] ISR_ID_RXDR    = 3'b010;
  localparam logic [2:0] ISR_ID_TIMEOUT = 3'b110;

  typedef struct packed {
    logic [4:0] reserved_hi;
    logic       rls_en;
    logic       reserved_1;
    logic       rxdr_en;
  } ier_t;

  typedef struct packed {
    logic [1:0] trigger;
    logic [3:0] reserved;
    logic       flush;
    logic       fifo_en;
  } fcr_t;

  typedef struct packed {
    logic [2:0] reserved_hi;
    logic       even_par;
    logic       par_en;
    logic [2:0] reserved_lo;
  } lcr_t;

  typedef struct packed {
    // Reads 11 on a 16550A
    logic [1:0] fifos_en;
    logic [1:0] zero;
    logic [2:0] id;
    // Low when an interrupt is pending
    logic       status;
  } isr_t;

  // One bus byte, meaning depends on address
  typedef union packed {
    logic [7:0] raw;
    ier_t       ier;
    fcr_t       fcr;
    lcr_t       lcr;
    isr_t       isr;
  } reg_word_u;

  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
    logic       frame_err;
    logic       brk;
  } rx_char_t;

endpackage

/* design/uart_cfg_pkg.sv */
package uart_cfg_pkg;

  // Line timing, fixed baud rate
  localparam int CLKS_PER_BIT = 8;
  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  // Mid start bit, counted from the cycle after the falling edge
  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

  // Receive FIFO geometry
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW = 4;
  localparam logic [FIFO_AW:0] FIFO_FULL = (FIFO_AW + 1)'(FIFO_DEPTH);

  // Trigger levels selected by FCR[7:6]
  localparam logic [FIFO_AW:0] TRIG_LVL_0 = (FIFO_AW + 1)'(1);
  localparam logic [FIFO_AW:0] TRIG_LVL_1 = (FIFO_AW + 1)'(4);
  localparam logic [FIFO_AW:0] TRIG_LVL_2 = (FIFO_AW + 1)'(8);
  localparam logic [FIFO_AW:0] TRIG_LVL_3 = (FIFO_AW + 1)'(14);

  // Character timeout, four 10-bit character times
  localparam int TIMEOUT_CLKS = 4 * 10 * CLKS_PER_BIT;
  localparam int TO_W = $clog2(TIMEOUT_CLKS + 1);
  localparam logic [TO_W-1:0] TIMEOUT_LAST = TO_W'(TIMEOUT_CLKS);

endpackage
